/* hdl/matmul_pkg.sv */
package matmul_pkg;

  // Input element formats
  // Both operands are signed with one fractional bit
  localparam int X_WIDTH = 8;
  localparam int X_FRAC_WIDTH = 1;
  localparam int Y_WIDTH = 8;
  localparam int Y_FRAC_WIDTH = 1;

  // Output element format
  // Plain signed integer after rounding
  localparam int OUT_WIDTH = 12;
  localparam int OUT_FRAC_WIDTH = 0;

  // Full-precision product of one X and one Y element
  localparam int PROD_WIDTH = X_WIDTH + Y_WIDTH;
  localparam int PROD_FRAC_WIDTH = X_FRAC_WIDTH + Y_FRAC_WIDTH;

  // One X matrix element
  typedef logic signed [X_WIDTH-1:0] x_elem_t;

  // One Y matrix element
  typedef logic signed [Y_WIDTH-1:0] y_elem_t;

  // One product before accumulation
  // Width does not depend on matrix size
  typedef logic signed [PROD_WIDTH-1:0] prod_t;

  // One output element
  typedef logic signed [OUT_WIDTH-1:0] out_t;

  // Rounded output element
  // Flag marks a clamped result
  typedef struct packed {
    out_t value;
    logic saturated;
  } round_t;

endpackage

/* hdl/fixed_vector_mult.sv */
`timescale 1ns/1ps

module fixed_vector_mult #(
  parameter int M = 4
) (
  input  logic                        clk,
  input  logic                        rst,

  // One row of X and one column of Y
  input  matmul_pkg::x_elem_t [M-1:0] x_row,
  input  matmul_pkg::y_elem_t [M-1:0] y_col,
  input  logic                        in_valid,
  output logic                        in_ready,

  // Element-wise products toward the adder tree
  output matmul_pkg::prod_t   [M-1:0] prod,
  output logic                        prod_valid,
  input  logic                        prod_ready
);

  // Stage takes new data when empty or draining
  logic load;

  assign load = !prod_valid || prod_ready;

  // Upstream sees the same load condition
  assign in_ready = load;

  // Valid bit of the product register
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
    end else if (load) begin
      prod_valid <= in_valid;
    end
  end

  // Product register
  // Full 16-bit result so no precision is lost here
  always_ff @(posedge clk) begin
    if (load && in_valid) begin
      for (int i = 0; i < M; i++) begin
        // Signed 8x8 multiply
        prod[i] <= $signed(x_row[i]) * $signed(y_col[i]);
      end
    end
  end

endmodule

/* hdl/fixed_adder_tree.sv */
`timescale 1ns/1ps

module fixed_adder_tree #(
  parameter int M = 4
) (
  input  logic                                        clk,
  input  logic                                        rst,

  // Products from the multiplier stage
  input  matmul_pkg::prod_t [M-1:0]                   prod,
  input  logic                                        prod_valid,
  output logic                                        prod_ready,

  // Reduced dot product
  output logic [matmul_pkg::PROD_WIDTH+$clog2(M)-1:0] sum,
  output logic                                        sum_valid,
  input  logic                                        sum_ready
);

  import matmul_pkg::*;

  // One registered level per halving
  localparam int LEVELS = $clog2(M);

  // Shared advance for every level of the tree
  logic advance;

  for (genvar l = 0; l <= LEVELS; l++) begin : gen_level
    // Node count and width at this level
    // Width grows by one bit per level
    localparam int CNT = (M + (1 << l) - 1) >> l;
    localparam int W = PROD_WIDTH + l;

    logic [CNT-1:0][W-1:0] node;
    logic                  vld;

    if (l == 0) begin : g_in
      // Level zero is the incoming product vector
      assign node = prod;
      assign vld  = prod_valid;
    end else begin : g_add
      localparam int PREV_CNT = (M + (1 << (l - 1)) - 1) >> (l - 1);

      // Nodes of the level above
      logic [PREV_CNT-1:0][W-2:0] prev;

      assign prev = gen_level[l-1].node;

      // Per-level valid bit
      always_ff @(posedge clk) begin
        if (rst) begin
          vld <= 1'b0;
        end else if (advance) begin
          vld <= gen_level[l-1].vld;
        end
      end

      always_ff @(posedge clk) begin
        if (advance) begin
          // Sign-extended pairwise sums
          for (int k = 0; k < PREV_CNT / 2; k++) begin
            node[k] <= $signed(prev[2*k]) + $signed(prev[2*k+1]);
          end
          // Odd leftover just gets registered
          if (PREV_CNT % 2 == 1) begin
            node[CNT-1] <= $signed(prev[PREV_CNT-1]);
          end
        end
      end
    end
  end

  // Last level holds a single node
  assign sum       = gen_level[LEVELS].node[0];
  assign sum_valid = gen_level[LEVELS].vld;

  // Tree moves unless the output is full and blocked
  assign advance    = !sum_valid || sum_ready;
  assign prod_ready = advance;

endmodule

/* hdl/fixed_dot_product.sv */
`timescale 1ns/1ps

module fixed_dot_product #(
  parameter int M = 4
) (
  input  logic                                        clk,
  input  logic                                        rst,

  // Operand vectors
  input  matmul_pkg::x_elem_t [M-1:0]                 x_row,
  input  matmul_pkg::y_elem_t [M-1:0]                 y_col,
  input  logic                                        in_valid,
  output logic                                        in_ready,

  // Dot product with 2 fractional bits
  output logic [matmul_pkg::PROD_WIDTH+$clog2(M)-1:0] sum,
  output logic                                        sum_valid,
  input  logic                                        sum_ready
);

  import matmul_pkg::*;

  // Product stream between the two stages
  prod_t [M-1:0] prod;
  logic          prod_valid;
  logic          prod_ready;

  // Stage 1
  // One cycle of registered multiplies
  fixed_vector_mult #(
    .M          (M)
  ) u_mult (
    .clk        (clk),
    .rst        (rst),
    .x_row      (x_row),
    .y_col      (y_col),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .prod       (prod),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready)
  );

  // Stages 2 onward
  // clog2(M) levels of registered adds
  fixed_adder_tree #(
    .M          (M)
  ) u_tree (
    .clk        (clk),
    .rst        (rst),
    .prod       (prod),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready),
    .sum        (sum),
    .sum_valid  (sum_valid),
    .sum_ready  (sum_ready)
  );

endmodule

/* hdl/fixed_round.sv */
`timescale 1ns/1ps

module fixed_round #(
  parameter int M = 4
) (
  input  logic [matmul_pkg::PROD_WIDTH+$clog2(M)-1:0] acc,
  output matmul_pkg::round_t                          res
);

  import matmul_pkg::*;

  // Accumulator format
  localparam int ACC_WIDTH = PROD_WIDTH + $clog2(M);

  // Fractional bits removed by rounding
  localparam int DROP = PROD_FRAC_WIDTH - OUT_FRAC_WIDTH;

  // Width left after the fraction is dropped
  localparam int SHIFT_WIDTH = ACC_WIDTH + 1 - DROP;

  // Half of one output LSB in accumulator units
  localparam logic signed [ACC_WIDTH:0] HALF = 1 << (DROP - 1);

  // Output range limits
  localparam out_t SAT_MAX = {1'b0, {(OUT_WIDTH - 1){1'b1}}};
  localparam out_t SAT_MIN = {1'b1, {(OUT_WIDTH - 1){1'b0}}};

  logic signed [ACC_WIDTH:0]     biased;
  logic signed [SHIFT_WIDTH-1:0] shifted;

  // Extra bit so adding the half never wraps
  assign biased = $signed({acc[ACC_WIDTH-1], acc}) + HALF;

  // Dropping low bits of a signed value is a floor
  // Together with the bias this rounds half toward plus infinity
  assign shifted = biased[ACC_WIDTH:DROP];

  // Clamp into the 12-bit range and flag it
  always_comb begin
    if (shifted > SAT_MAX) begin
      res.value     = SAT_MAX;
      res.saturated = 1'b1;
    end else if (shifted < SAT_MIN) begin
      res.value     = SAT_MIN;
      res.saturated = 1'b1;
    end else begin
      res.value     = shifted[OUT_WIDTH-1:0];
      res.saturated = 1'b0;
    end
  end

endmodule

/* hdl/simple_matmul.sv */
`timescale 1ns/1ps

module simple_matmul #(
  parameter int N = 2,
  parameter int M = 4,
  parameter int K = 2
) (
  input  logic                            clk,
  input  logic                            rst,

  // X matrix in row-major order
  input  matmul_pkg::x_elem_t [N*M-1:0]   x_data,
  input  logic                            x_valid,
  output logic                            x_ready,

  // Y matrix stored column by column
  input  matmul_pkg::y_elem_t [M*K-1:0]   y_data,
  input  logic                            y_valid,
  output logic                            y_ready,

  // Product matrix in row-major order
  output matmul_pkg::round_t  [N*K-1:0]   out_data,
  output logic                            out_valid,
  input  logic                            out_ready
);

  import matmul_pkg::*;

  // Dot-product result width
  localparam int ACC_WIDTH = PROD_WIDTH + $clog2(M);

  // Joined input handshake
  logic pair_valid;
  logic pipe_ready;

  // Rows of X and columns of Y
  x_elem_t [N-1:0][M-1:0] x_rows;
  y_elem_t [K-1:0][M-1:0] y_cols;

  // Per-element pipeline outputs
  logic [N-1:0][K-1:0]                dp_ready;
  logic [N-1:0][K-1:0]                dp_valid;
  logic [N-1:0][K-1:0][ACC_WIDTH-1:0] dp_sum;

  // A pair only moves when both sides are present
  assign pair_valid = x_valid && y_valid;
  assign x_ready    = pipe_ready && y_valid;
  assign y_ready    = pipe_ready && x_valid;

  // Row i of X
  for (genvar i = 0; i < N; i++) begin : gen_rows
    assign x_rows[i] = x_data[i*M +: M];
  end

  // Column j of Y is already contiguous
  // so the transpose is plain slicing
  for (genvar j = 0; j < K; j++) begin : gen_cols
    assign y_cols[j] = y_data[j*M +: M];
  end

  // N x K grid of dot-product pipelines
  for (genvar i = 0; i < N; i++) begin : gen_out_row
    for (genvar j = 0; j < K; j++) begin : gen_out_col

      fixed_dot_product #(
        .M         (M)
      ) u_dot (
        .clk       (clk),
        .rst       (rst),
        .x_row     (x_rows[i]),
        .y_col     (y_cols[j]),
        .in_valid  (pair_valid),
        .in_ready  (dp_ready[i][j]),
        .sum       (dp_sum[i][j]),
        .sum_valid (dp_valid[i][j]),
        .sum_ready (out_ready)
      );

      // Rounded and clamped element (i,j)
      fixed_round #(
        .M   (M)
      ) u_round (
        .acc (dp_sum[i][j]),
        .res (out_data[i*K+j])
      );

    end
  end

  // All pipelines run in lockstep
  // Element (0,0) speaks for the whole grid
  assign pipe_ready = dp_ready[0][0];
  assign out_valid  = dp_valid[0][0];

endmodule

/* sim/tb_simple_matmul.sv */
`timescale 1ns/1ps

module tb_simple_matmul;

  import matmul_pkg::*;

  localparam int N = 2;
  localparam int M = 4;
  localparam int K = 2;
  // Far more than all tests need together
  localparam int TIMEOUT = 4000;

  typedef x_elem_t [N*M-1:0] x_mat_t;
  typedef y_elem_t [M*K-1:0] y_mat_t;
  typedef round_t  [N*K-1:0] out_mat_t;

  logic     clk;
  logic     rst;
  x_mat_t   x_data;
  logic     x_valid;
  logic     x_ready;
  y_mat_t   y_data;
  logic     y_valid;
  logic     y_ready;
  out_mat_t out_data;
  logic     out_valid;
  logic     out_ready;

  // Scoreboard and bookkeeping
  out_mat_t    exp_q[$];
  int          errors = 0;
  int          checks = 0;
  int          out_count = 0;
  int          cycle = 0;
  int          last_in_cycle = 0;
  int          last_out_cycle = 0;
  logic [31:0] data_state = 32'd48;
  logic [31:0] ready_state = 32'd48;
  logic        bp_on;

  simple_matmul #(
    .N         (N),
    .M         (M),
    .K         (K)
  ) dut (
    .clk       (clk),
    .rst       (rst),
    .x_data    (x_data),
    .x_valid   (x_valid),
    .x_ready   (x_ready),
    .y_data    (y_data),
    .y_valid   (y_valid),
    .y_ready   (y_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // LCG step with the classic C library constants
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Reference for element (i,j)
  // Exact integer sum in quarter units then floor((acc + 2) / 4) and clamp
  function automatic round_t ref_elem(input x_mat_t x, input y_mat_t y, input int i,
                                      input int j);
    int     acc;
    int     r;
    round_t res;
    acc = 0;
    for (int k = 0; k < M; k++) begin
      acc = acc + int'(x[i*M+k]) * int'(y[j*M+k]);
    end
    r = (acc + 2) >>> 2;
    res.saturated = (r > 2047) || (r < -2048);
    if (r > 2047) begin
      r = 2047;
    end else if (r < -2048) begin
      r = -2048;
    end
    res.value = r[OUT_WIDTH-1:0];
    return res;
  endfunction

  task automatic check_elem(input string name, input round_t got, input round_t exp);
    checks++;
    if (got.value !== exp.value) begin
      errors++;
      $display("[ERROR] %s.value got 0x%h expected 0x%h", name, got.value, exp.value);
    end
    if (got.saturated !== exp.saturated) begin
      errors++;
      $display("[ERROR] %s.saturated got 0x%h expected 0x%h", name, got.saturated,
               exp.saturated);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // Cycle counter doubles as the run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // One expected matrix per accepted pair
  always @(posedge clk) begin
    out_mat_t e;
    if (!rst && x_valid && x_ready) begin
      if (!(y_valid && y_ready)) begin
        errors++;
        $display("X was accepted without its Y partner");
      end
      for (int i = 0; i < N; i++) begin
        for (int j = 0; j < K; j++) begin
          e[i*K+j] = ref_elem(x_data, y_data, i, j);
        end
      end
      exp_q.push_back(e);
      last_in_cycle = cycle;
    end
  end

  // Output transfers checked in order against the queue
  always @(posedge clk) begin
    out_mat_t e;
    if (!rst && out_valid && out_ready) begin
      out_count++;
      last_out_cycle = cycle;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output transfer seen with no pair outstanding");
      end else begin
        e = exp_q.pop_front();
        for (int n = 0; n < N*K; n++) begin
          check_elem($sformatf("out_data[%0d]", n), out_data[n], e[n]);
        end
      end
    end
  end

  // Starts and ends 1 ns after a rising edge
  task automatic drive_pair(input x_mat_t x, input y_mat_t y);
    x_data  = x;
    y_data  = y;
    x_valid = 1'b1;
    y_valid = 1'b1;
    @(posedge clk);
    while (!x_ready) @(posedge clk);
    #1;
    x_valid = 1'b0;
    y_valid = 1'b0;
  endtask

  task automatic drain;
    while (exp_q.size() != 0) @(posedge clk);
    #1;
  endtask

  task automatic fill_random(output x_mat_t x, output y_mat_t y);
    for (int n = 0; n < N*M; n++) begin
      data_state = lcg_step(data_state);
      x[n] = data_state[23:16];
    end
    for (int n = 0; n < M*K; n++) begin
      data_state = lcg_step(data_state);
      y[n] = data_state[23:16];
    end
  endtask

  // Identity rows in X, Y holds small whole numbers
  task automatic known_matrices;
    x_mat_t x;
    y_mat_t y;
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < M; k++) begin
        x[i*M+k] = (k == i) ? 8'sd2 : 8'sd0;
      end
    end
    for (int n = 0; n < M*K; n++) begin
      y[n] = 2 * (n + 1);
    end
    drive_pair(x, y);
    drain();
  endtask

  // Sums of 0.5, 0.25, -0.5, -1.0, then -1.5 and 1.5
  task automatic rounding_signs;
    x_mat_t x;
    y_mat_t y;
    x = '0;
    y = '0;
    x[0] = 1;
    x[M] = -1;
    x[M+1] = -3;
    y[0] = 2;
    y[M] = 1;
    y[M+1] = 1;
    drive_pair(x, y);
    x[0] = -3;
    x[M] = 3;
    x[M+1] = 0;
    drive_pair(x, y);
    drain();
  endtask

  // Operands at both ends of the 8-bit range
  task automatic saturation_limits;
    x_mat_t x;
    y_mat_t y;
    for (int k = 0; k < M; k++) begin
      x[k] = -128;
      x[M+k] = (k < 2) ? 8'sd127 : -8'sd128;
      y[k] = -128;
      y[M+k] = (k % 2 == 0) ? 8'sd127 : -8'sd128;
    end
    drive_pair(x, y);
    x = {N*M{8'sd127}};
    y = {M*K{-8'sd128}};
    drive_pair(x, y);
    drain();
  endtask

  // X waits alone until Y shows up
  task automatic join_hold;
    x_mat_t x;
    y_mat_t y;
    int     start;
    start = out_count;
    fill_random(x, y);
    x_data  = x;
    y_data  = y;
    x_valid = 1'b1;
    repeat (8) begin
      @(posedge clk);
      if (x_ready) begin
        errors++;
        $display("x_ready was high while y_valid was low");
      end
      // Y side is offered a slot as soon as X is valid
      if (!y_ready) begin
        errors++;
        $display("y_ready was low while x_valid was high and the pipeline was empty");
      end
    end
    check_count("outputs during hold", out_count - start, 0);
    #1;
    drive_pair(x, y);
    drain();
    check_count("outputs after join", out_count - start, 1);
  endtask

  // Back-to-back pairs against random back-pressure
  task automatic random_stream;
    x_mat_t x;
    y_mat_t y;
    int     start;
    start = out_count;
    bp_on = 1'b1;
    fork
      begin
        for (int p = 0; p < 40; p++) begin
          fill_random(x, y);
          drive_pair(x, y);
        end
        drain();
        bp_on = 1'b0;
      end
      while (bp_on) begin
        @(posedge clk);
        #1;
        ready_state = lcg_step(ready_state);
        out_ready = ready_state[20];
      end
    join
    out_ready = 1'b1;
    check_count("streamed outputs", out_count - start, 40);
  endtask

  // Empty pipeline, output always ready
  task automatic single_latency;
    x_mat_t x;
    y_mat_t y;
    fill_random(x, y);
    out_ready = 1'b1;
    drive_pair(x, y);
    drain();
    check_count("latency", last_out_cycle - last_in_cycle, 3);
  endtask

  initial begin
    rst       = 1'b1;
    x_data    = '0;
    x_valid   = 1'b0;
    y_data    = '0;
    y_valid   = 1'b0;
    out_ready = 1'b1;
    bp_on     = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    known_matrices();
    rounding_signs();
    saturation_limits();
    join_hold();
    random_stream();
    single_latency();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* simple_matmul.f */
hdl/matmul_pkg.sv
hdl/fixed_vector_mult.sv
hdl/fixed_adder_tree.sv
hdl/fixed_dot_product.sv
hdl/fixed_round.sv
hdl/simple_matmul.sv
sim/tb_simple_matmul.sv

/* Bender.yml */
package:
  name: simple_matmul

sources:
  # RTL in compile order
  - hdl/matmul_pkg.sv
  - hdl/fixed_vector_mult.sv
  - hdl/fixed_adder_tree.sv
  - hdl/fixed_dot_product.sv
  - hdl/fixed_round.sv
  - hdl/simple_matmul.sv

  # Testbench
  - target: simulation
    files:
      - sim/tb_simple_matmul.sv
